//--- bch_chien_search.sv
// Chien search stage of the BCH decoder.
// Tests positions 14 down to 0, flips located bits and checks the root count.
`timescale 1ns/1ps

module bch_chien_search
	import bch_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input loc_job_t in_job,
	input logic ack_done,
	output logic ready,
	output logic done,
	output message_t message,
	output err_count_t err_count,
	output logic failure
);

	logic busy;
	logic [3:0] pos;
	codeword_t corrected;
	// terms of sig2 + sig1 a^p + sig0 a^2p, zero exactly at error locators.
	gf_elem_t term0;
	gf_elem_t term1;
	gf_elem_t term2;
	err_count_t roots;
	err_count_t roots_next;
	logic hit;

	assign hit = (term0 ^ term1 ^ term2) == '0;
	assign roots_next = roots + err_count_t'(hit);
	assign ready = !busy && (!done || ack_done);
	assign message = corrected[bch_n-1 -: bch_k];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			pos <= '0;
			roots <= '0;
			err_count <= '0;
			failure <= 1'b0;
		end else begin
			if (ack_done)
				done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				pos <= 4'(bch_n - 1);
				roots <= '0;
				err_count <= in_job.err_count;
				failure <= 1'b0;
			end else if (busy) begin
				roots <= roots_next;
				pos <= pos - 4'd1;
				if (pos == 4'd0) begin
					busy <= 1'b0;
					done <= 1'b1;
					failure <= roots_next != err_count; // locator did not split.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			corrected <= in_job.codeword;
			term0 <= in_job.sigma.sig2;
			term1 <= gf_mul(in_job.sigma.sig1, gf_alpha_pow(bch_n - 1));
			term2 <= gf_mul(in_job.sigma.sig0, gf_alpha_pow(2 * (bch_n - 1)));
		end else if (busy) begin
			if (hit)
				corrected[pos] <= ~corrected[pos];
			// term0 steps by alpha^0 and holds.
			term1 <= gf_mul(term1, gf_alpha_pow(-1));
			term2 <= gf_mul(term2, gf_alpha_pow(-2));
		end
	end

	a_root_bound: assert property (@(posedge clk) disable iff (!rst_n)
		roots <= err_count_t'(bch_t));

endmodule

//--- bch_decoder.sv
// Top level of the BCH(15,7) decoder.
// Chains syndrome, BMA and Chien stages; each hand-off is done gated by downstream ready.
`timescale 1ns/1ps

module bch_decoder
	import bch_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input codeword_t codeword,
	input logic ack_done,
	output logic ready,
	output logic done,
	output message_t message,
	output err_count_t err_count,
	output logic failure
);

	logic syn_ready;
	logic syn_done;
	syn_job_t syn_job;
	logic bma_start;
	logic bma_ready;
	logic bma_done;
	loc_job_t loc_job;
	logic chien_start;
	logic chien_ready;

	assign ready = syn_ready;
	assign bma_start = syn_done && bma_ready;     // also acks the syndrome stage.
	assign chien_start = bma_done && chien_ready; // also acks the BMA stage.

	bch_syndrome i_bch_syndrome (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.codeword(codeword),
		.ack_done(bma_start),
		.ready(syn_ready),
		.done(syn_done),
		.job(syn_job)
	);

	bch_sigma_bma i_bch_sigma_bma (
		.clk(clk),
		.rst_n(rst_n),
		.start(bma_start),
		.in_job(syn_job),
		.ack_done(chien_start),
		.ready(bma_ready),
		.done(bma_done),
		.out_job(loc_job)
	);

	bch_chien_search i_bch_chien_search (
		.clk(clk),
		.rst_n(rst_n),
		.start(chien_start),
		.in_job(loc_job),
		.ack_done(ack_done),
		.ready(chien_ready),
		.done(done),
		.message(message),
		.err_count(err_count),
		.failure(failure)
	);

endmodule

//--- bch_pkg.sv
// Shared definitions for the BCH(15,7) t=2 decoder over GF(2^4).
// Holds code constants, field types, stage hand-off structs and field arithmetic.
package bch_pkg;

	localparam int gf_m = 4;   // field width.
	localparam int bch_t = 2;  // correctable errors.
	localparam int bch_n = 15; // code length.
	localparam int bch_k = 7;  // message length.

	typedef logic [gf_m-1:0] gf_elem_t;
	typedef logic [bch_n-1:0] codeword_t;
	typedef logic [bch_k-1:0] message_t;
	typedef logic [$clog2(bch_t+1)-1:0] err_count_t;

	// low bits of x^4 + x + 1.
	localparam gf_elem_t gf_poly = 4'h3;

	typedef struct packed {
		gf_elem_t s1;
		gf_elem_t s2;
		gf_elem_t s3;
		gf_elem_t s4;
	} syndromes_t;

	typedef struct packed {
		gf_elem_t sig0;
		gf_elem_t sig1;
		gf_elem_t sig2;
	} sigma_t;

	// syndrome stage to BMA stage.
	typedef struct packed {
		codeword_t codeword;
		syndromes_t syndromes;
	} syn_job_t;

	// BMA stage to Chien stage.
	typedef struct packed {
		codeword_t codeword;
		sigma_t sigma;
		err_count_t err_count;
	} loc_job_t;

	typedef enum logic [1:0] {
		bma_idle,
		bma_discrepancy,
		bma_update,
		bma_finish
	} bma_state_t;

	// polynomial basis multiply, shift and add.
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t p;
		gf_elem_t x;
		p = '0;
		x = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				p = p ^ x;
			x = {x[gf_m-2:0], 1'b0} ^ (x[gf_m-1] ? gf_poly : gf_elem_t'(0));
		end
		return p;
	endfunction

	// a^-1 = a^14 = a^2 * a^4 * a^8, zero maps to zero.
	function automatic gf_elem_t gf_inv(gf_elem_t a);
		gf_elem_t r;
		gf_elem_t sq;
		r = gf_elem_t'(1);
		sq = a;
		for (int i = 1; i < gf_m; i++) begin
			sq = gf_mul(sq, sq);
			r = gf_mul(r, sq);
		end
		return r;
	endfunction

	// alpha^e for any integer e, reduced mod 15.
	function automatic gf_elem_t gf_alpha_pow(int e);
		gf_elem_t r;
		int k;
		r = gf_elem_t'(1);
		k = e % bch_n;
		if (k < 0)
			k = k + bch_n;
		for (int i = 0; i < bch_n - 1; i++) begin
			if (i < k)
				r = gf_mul(r, gf_elem_t'(2));
		end
		return r;
	endfunction

endpackage

//--- bch_sigma_bma.sv
// Error locator stage of the BCH decoder.
// Binary Berlekamp-Massey with inversion, two cycles per iteration plus a finish cycle.
`timescale 1ns/1ps

module bch_sigma_bma
	import bch_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input syn_job_t in_job,
	input logic ack_done,
	output logic ready,
	output logic done,
	output loc_job_t out_job
);

	bma_state_t state;
	logic iter;
	logic [1:0] step;
	codeword_t cw;
	syndromes_t syn;
	sigma_t sigma;
	sigma_t sigma_next;
	gf_elem_t [2:0] beta; // beta[i] is the x^i coefficient.
	gf_elem_t d_p;
	gf_elem_t d;
	gf_elem_t disc;
	gf_elem_t scale;
	gf_elem_t s1_in;
	err_count_t err_count;
	logic bsel;
	logic [2:0] l_next;

	function automatic gf_elem_t syn_at(syndromes_t s, int idx);
		case (idx)
			1: return s.s1;
			2: return s.s2;
			3: return s.s3;
			4: return s.s4;
			default: return '0;
		endcase
	endfunction

	assign s1_in = in_job.syndromes.s1;
	assign step = 2'(iter) + 2'd1; // step 0 is folded into the initial values.
	assign ready = (state == bma_idle) && (!done || ack_done);

	// d_r = sum sigma_i * S_(2r+1-i), nothing left to resolve once r reaches t.
	always_comb begin
		if (int'(step) < bch_t)
			disc = gf_mul(sigma.sig0, syn_at(syn, 2 * int'(step) + 1)) ^
				gf_mul(sigma.sig1, syn_at(syn, 2 * int'(step))) ^
				gf_mul(sigma.sig2, syn_at(syn, 2 * int'(step) - 1));
		else
			disc = '0;
	end

	assign scale = gf_mul(d, gf_inv(d_p)); // d_r / d_p.
	assign bsel = (d != '0) && (step >= err_count);
	assign l_next = {step, 1'b1} - {1'b0, err_count}; // 2r + 1 - L.

	always_comb begin
		sigma_next.sig0 = sigma.sig0 ^ gf_mul(scale, beta[0]);
		sigma_next.sig1 = sigma.sig1 ^ gf_mul(scale, beta[1]);
		sigma_next.sig2 = sigma.sig2 ^ gf_mul(scale, beta[2]);
	end

	assign out_job.codeword = cw;
	assign out_job.sigma = sigma;
	assign out_job.err_count = err_count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= bma_idle;
			iter <= 1'b0;
			err_count <= '0;
			done <= 1'b0;
		end else begin
			if (ack_done)
				done <= 1'b0;
			case (state)
				bma_idle: begin
					if (start) begin
						state <= bma_discrepancy;
						iter <= 1'b0;
						err_count <= err_count_t'(s1_in != '0);
					end
				end
				bma_discrepancy: state <= bma_update;
				bma_update: begin
					// three or more errors saturate and surface in the Chien check.
					if (bsel)
						err_count <= (l_next > 3'(bch_t)) ? err_count_t'(bch_t) : l_next[1:0];
					if (int'(iter) == bch_t - 1) begin
						state <= bma_finish;
					end else begin
						iter <= iter + 1'b1;
						state <= bma_discrepancy;
					end
				end
				bma_finish: begin
					state <= bma_idle;
					done <= 1'b1;
				end
				default: state <= bma_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			bma_idle: begin
				if (start) begin
					cw <= in_job.codeword;
					syn <= in_job.syndromes;
					sigma.sig0 <= gf_elem_t'(1); // sigma = 1 + S1 x.
					sigma.sig1 <= s1_in;
					sigma.sig2 <= '0;
					beta[2] <= gf_elem_t'(s1_in != '0); // S1 ? x^2 : x^3 with x^3 out of range.
					beta[1] <= '0;
					beta[0] <= '0;
					d_p <= (s1_in != '0) ? s1_in : gf_elem_t'(1);
				end
			end
			bma_discrepancy: d <= disc;
			bma_update: begin
				sigma <= sigma_next;
				if (bsel) begin
					beta <= {sigma.sig0, {2 * gf_m{1'b0}}}; // x^2 * sigma.
					d_p <= d;
				end else begin
					beta <= {beta[0], {2 * gf_m{1'b0}}};
				end
			end
			default: ;
		endcase
	end

	a_err_bound: assert property (@(posedge clk) disable iff (!rst_n)
		err_count <= err_count_t'(bch_t));
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> state == bma_idle);

endmodule

//--- bch_syndrome.sv
// Syndrome stage of the BCH decoder.
// Evaluates the received word at alpha^1..alpha^4, one bit per cycle, MSB first.
`timescale 1ns/1ps

module bch_syndrome
	import bch_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input codeword_t codeword,
	input logic ack_done,
	output logic ready,
	output logic done,
	output syn_job_t job
);

	logic busy;
	logic [3:0] cnt;
	codeword_t cw;
	syndromes_t acc;
	logic bit_in;

	assign bit_in = cw[4'(bch_n - 1) - cnt]; // highest power goes first.
	assign ready = !busy && (!done || ack_done);

	assign job.codeword = cw;
	assign job.syndromes = acc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else begin
			if (ack_done)
				done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				cnt <= cnt + 4'd1;
				if (cnt == 4'(bch_n - 1)) begin
					busy <= 1'b0;
					done <= 1'b1; // all 15 bits folded in.
				end
			end
		end
	end

	// Horner step acc = acc * alpha^j + bit for each syndrome j.
	always_ff @(posedge clk) begin
		if (start) begin
			cw <= codeword;
			acc <= '0;
		end else if (busy) begin
			acc.s1 <= gf_mul(acc.s1, gf_alpha_pow(1)) ^ gf_elem_t'(bit_in);
			acc.s2 <= gf_mul(acc.s2, gf_alpha_pow(2)) ^ gf_elem_t'(bit_in);
			acc.s3 <= gf_mul(acc.s3, gf_alpha_pow(3)) ^ gf_elem_t'(bit_in);
			acc.s4 <= gf_mul(acc.s4, gf_alpha_pow(4)) ^ gf_elem_t'(bit_in);
		end
	end

	a_start_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> ready);

endmodule

//--- build.f
bch_pkg.sv
bch_syndrome.sv
bch_sigma_bma.sv
bch_chien_search.sv
bch_decoder.sv
tb_bch_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -o pipefail

verilator --binary --timing --assert -f build.f --top-module tb_bch_decoder \
	-o tb_bch_decoder \
	&& ./obj_dir/tb_bch_decoder 2>&1 | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; } || exit 0

//--- tb_bch_decoder.sv
// Testbench for the BCH(15,7) decoder.
// Encodes table messages in software, adds random bit errors, checks results in issue order.
`timescale 1ns/1ps

module tb_bch_decoder
	import bch_pkg::*;
;

	localparam logic [8:0] gen_poly = 9'h1d1;        // x^8 + x^7 + x^6 + x^4 + 1.
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;
	localparam int wait_limit = 200;
	localparam int drain_limit = 600;
	localparam int n_vec = 14;

	typedef struct packed {
		message_t msg;
		logic [1:0] n_err;
		logic [3:0] fixed_pos; // 4'hf picks a random position.
		logic [7:0] hold;      // cycles to withhold ack_done.
	} vec_t;

	typedef struct packed {
		message_t msg;
		err_count_t n_err;
		logic [7:0] hold;
	} expect_t;

	localparam vec_t vectors [0:n_vec-1] = '{
		'{7'h00, 2'd0, 4'hf, 8'd0},
		'{7'h5a, 2'd0, 4'hf, 8'd0},
		'{7'h7f, 2'd1, 4'h0, 8'd0},
		'{7'h2c, 2'd1, 4'he, 8'd0},
		'{7'h13, 2'd1, 4'hf, 8'd0},
		'{7'h66, 2'd1, 4'hf, 8'd6},
		'{7'h41, 2'd2, 4'hf, 8'd0},
		'{7'h3e, 2'd2, 4'h0, 8'd0},
		'{7'h55, 2'd2, 4'he, 8'd40},
		'{7'h0b, 2'd2, 4'hf, 8'd0},
		'{7'h70, 2'd2, 4'hf, 8'd0},
		'{7'h29, 2'd1, 4'hf, 8'd0},
		'{7'h6d, 2'd0, 4'hf, 8'd3},
		'{7'h1f, 2'd2, 4'hf, 8'd0}
	};

	logic clk;
	logic rst_n;
	logic start;
	codeword_t codeword;
	logic ack_done;
	logic ready;
	logic done;
	message_t message;
	err_count_t err_count;
	logic failure;

	logic [31:0] lfsr_state;
	expect_t pending[$]; // expected results in issue order.
	int results_seen;
	int max_in_flight;
	int mismatch_count;
	int other_count;
	logic aborted;

	bch_decoder i_bch_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.codeword(codeword),
		.ack_done(ack_done),
		.ready(ready),
		.done(done),
		.message(message),
		.err_count(err_count),
		.failure(failure)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]}; // one step per bit.
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic pick_pos(input int avoid, output int p);
		logic [31:0] r;
		p = bch_n;
		while (p >= bch_n || p == avoid) begin
			draw_bits(4, r);
			p = int'(r[3:0]);
		end
	endtask

	// systematic encoding, remainder of msg * x^8 divided by the generator.
	function automatic codeword_t encode(message_t msg);
		codeword_t r;
		r = {msg, 8'h00};
		for (int i = bch_n - 1; i >= bch_n - bch_k; i--) begin
			if (r[4'(i)])
				r = r ^ (codeword_t'(gen_poly) << (i - (bch_n - bch_k)));
		end
		return {msg, r[7:0]};
	endfunction

	task automatic make_word(input vec_t v, output codeword_t rx);
		int p0;
		int p1;
		rx = encode(v.msg);
		p0 = -1;
		if (v.n_err != 2'd0) begin
			if (v.fixed_pos != 4'hf)
				p0 = int'(v.fixed_pos);
			else
				pick_pos(-1, p0);
			rx = rx ^ (codeword_t'(1) << p0);
		end
		if (v.n_err == 2'd2) begin
			pick_pos(p0, p1); // second error never repeats the first.
			rx = rx ^ (codeword_t'(1) << p1);
		end
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			mismatch_count++;
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!ready && !aborted && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!ready && !aborted) begin
			$display("Timeout: ready stayed low for %0d cycles", wait_limit);
			other_count++;
			aborted = 1'b1;
		end
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!done && !aborted && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!done && !aborted) begin
			$display("Timeout: done did not rise within %0d cycles", wait_limit);
			other_count++;
			aborted = 1'b1;
		end
	endtask

	// issue side.
	initial begin : stimulus
		codeword_t rx;
		expect_t e;
		int cycles;
		rst_n = 1'b0;
		start = 1'b0;
		codeword = '0;
		lfsr_state = 32'hea60_9a20;
		results_seen = 0;
		max_in_flight = 0;
		mismatch_count = 0;
		other_count = 0;
		aborted = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check("done", 32'(done), 32'h0); // idle state after reset.
		check("ready", 32'(ready), 32'h1);
		for (int i = 0; i < n_vec; i++) begin
			make_word(vectors[i], rx);
			e.msg = vectors[i].msg;
			e.n_err = vectors[i].n_err;
			e.hold = vectors[i].hold;
			wait_ready();
			if (aborted)
				break;
			@(posedge clk);
			start <= 1'b1;
			codeword <= rx;
			pending.push_back(e);
			if (pending.size() > max_in_flight)
				max_in_flight = pending.size();
			@(posedge clk);
			start <= 1'b0;
		end
		cycles = 0;
		while (!aborted && results_seen < n_vec && cycles < drain_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!aborted && results_seen < n_vec) begin
			$display("Timeout: only %0d of %0d results arrived", results_seen, n_vec);
			other_count++;
		end
		if (!aborted && max_in_flight < 2) begin
			$display("Pipeline never held more than one codeword at a time");
			other_count++;
		end
		finish_run();
	end

	// result side, acks each result after its hold time.
	initial begin : result_reader
		expect_t e;
		ack_done = 1'b0;
		for (int i = 0; i < n_vec; i++) begin
			wait_done();
			if (aborted)
				break;
			if (pending.size() == 0) begin
				$display("done rose with no codeword outstanding");
				other_count++;
				e = '0;
			end else begin
				e = pending.pop_front();
			end
			check("message", 32'(message), 32'(e.msg));
			check("err_count", 32'(err_count), 32'(e.n_err));
			check("failure", 32'(failure), 32'h0);
			for (int h = 0; h < int'(e.hold); h++) begin
				@(negedge clk);
				check("done", 32'(done), 32'h1); // result must hold until ack.
				check("message", 32'(message), 32'(e.msg));
				check("err_count", 32'(err_count), 32'(e.n_err));
				check("failure", 32'(failure), 32'h0);
			end
			@(posedge clk);
			ack_done <= 1'b1;
			@(posedge clk);
			ack_done <= 1'b0;
			results_seen++;
		end
	end

endmodule
